//--- common/bus_pkg.sv
package bus_pkg;

	localparam int addr_len = 12;        // serial address bits
	localparam int data_len = 8;         // serial data bits
	localparam int slave_count = 3;

	// memory depth per slave, as address bits
	localparam int slave0_addr_len = 12; // 4k
	localparam int slave1_addr_len = 11; // 2k, used by slaves 1 and 2

	localparam int bit_cnt_len = $clog2(addr_len);

	localparam logic [bit_cnt_len-1:0] addr_last = bit_cnt_len'(addr_len - 1);
	localparam logic [bit_cnt_len-1:0] data_last = bit_cnt_len'(data_len - 1);

	typedef logic [$clog2(slave_count)-1:0] slave_sel_t;
	typedef logic [addr_len-1:0] addr_t;
	typedef logic [data_len-1:0] data_t;

	typedef enum logic [2:0] {
		m_idle,
		m_request,   // waiting for grant
		m_send_addr,
		m_send_data,
		m_recv_data,
		m_finish     // done pulse
	} master_state_t;

	typedef enum logic [1:0] {
		s_idle,
		s_get_addr,
		s_get_data,
		s_send_data
	} slave_state_t;

endpackage

//--- common/serial_if.sv
interface serial_if;

	// master to slave
	logic master_valid; // serial bit present
	logic addr_bit;
	logic data_bit;
	logic write_en;     // held for the whole transfer
	logic read_en;
	logic master_ready; // master taking read bits

	// slave to master
	logic slave_ready;  // slave idle
	logic slave_valid;
	logic rdata_bit;

	modport master (
		output master_valid,
		output addr_bit,
		output data_bit,
		output write_en,
		output read_en,
		output master_ready,
		input  slave_ready,
		input  slave_valid,
		input  rdata_bit
	);

	modport slave (
		input  master_valid,
		input  addr_bit,
		input  data_bit,
		input  write_en,
		input  read_en,
		input  master_ready,
		output slave_ready,
		output slave_valid,
		output rdata_bit
	);

endinterface

//--- master/bus_master.sv
module bus_master (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  logic                write,
	input  bus_pkg::slave_sel_t slave,
	input  bus_pkg::addr_t      addr,
	input  bus_pkg::data_t      wdata,
	output logic                busy,
	output logic                done,
	output bus_pkg::data_t      rdata,
	output logic                request,
	output bus_pkg::slave_sel_t req_slave,
	input  logic                grant,
	serial_if.master            link
);

	bus_pkg::master_state_t state;
	logic [bus_pkg::bit_cnt_len-1:0] bit_cnt;

	logic                cmd_write;
	bus_pkg::slave_sel_t cmd_slave;
	bus_pkg::addr_t      addr_sh; // address shift out, lsb first
	bus_pkg::data_t      data_sh; // write data shift out
	bus_pkg::data_t      rx_sh;   // read byte assembly

	logic cmd_take;
	logic in_xfer;

	// a new command is only taken when not busy
	assign cmd_take = start && (state == bus_pkg::m_idle || state == bus_pkg::m_finish);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= bus_pkg::m_idle;
			bit_cnt <= '0;
		end else begin
			case (state)
				bus_pkg::m_idle: begin
					if (cmd_take)
						state <= bus_pkg::m_request;
				end
				bus_pkg::m_request: begin
					if (grant && link.slave_ready) begin // bus ours and slave free
						state   <= bus_pkg::m_send_addr;
						bit_cnt <= '0;
					end
				end
				bus_pkg::m_send_addr: begin
					if (bit_cnt == bus_pkg::addr_last) begin
						bit_cnt <= '0;
						state   <= cmd_write ? bus_pkg::m_send_data : bus_pkg::m_recv_data;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				bus_pkg::m_send_data: begin
					if (bit_cnt == bus_pkg::data_last) begin
						bit_cnt <= '0;
						state   <= bus_pkg::m_finish;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				bus_pkg::m_recv_data: begin
					if (link.slave_valid) begin
						if (bit_cnt == bus_pkg::data_last) begin
							bit_cnt <= '0;
							state   <= bus_pkg::m_finish;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				bus_pkg::m_finish: begin
					state <= cmd_take ? bus_pkg::m_request : bus_pkg::m_idle; // back to back
				end
				default: state <= bus_pkg::m_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_take) begin
			cmd_write <= write;
			cmd_slave <= slave;
			addr_sh   <= addr;
			data_sh   <= wdata;
		end else begin
			if (state == bus_pkg::m_send_addr)
				addr_sh <= addr_sh >> 1;
			if (state == bus_pkg::m_send_data)
				data_sh <= data_sh >> 1;
		end
		if (state == bus_pkg::m_recv_data && link.slave_valid)
			rx_sh <= {link.rdata_bit, rx_sh[bus_pkg::data_len-1:1]};
	end

	assign in_xfer = state inside {bus_pkg::m_send_addr, bus_pkg::m_send_data,
		bus_pkg::m_recv_data};

	assign busy      = state != bus_pkg::m_idle && state != bus_pkg::m_finish;
	assign done      = state == bus_pkg::m_finish;
	assign rdata     = rx_sh;
	assign request   = state == bus_pkg::m_request;
	assign req_slave = cmd_slave;

	assign link.master_valid = state == bus_pkg::m_send_addr || state == bus_pkg::m_send_data;
	assign link.addr_bit     = addr_sh[0];
	assign link.data_bit     = data_sh[0];
	assign link.write_en     = in_xfer && cmd_write;
	assign link.read_en      = in_xfer && !cmd_write;
	assign link.master_ready = state == bus_pkg::m_recv_data;

	// grant comes from the arbiter, the bits leave through the mux
	a_valid_needs_grant: assert property (
		@(posedge clk) disable iff (!rst_n) link.master_valid |-> grant
	) else $error("master_valid without grant");

endmodule

//--- interconnect/bus_arbiter.sv
module bus_arbiter (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                m1_request,
	input  logic                m2_request,
	input  bus_pkg::slave_sel_t m1_slave,
	input  bus_pkg::slave_sel_t m2_slave,
	input  logic                trans_done,
	output logic                m1_grant,
	output logic                m2_grant,
	output logic                bus_busy,
	output logic                sel_master,
	output bus_pkg::slave_sel_t sel_slave
);

	// fixed priority, master 1 wins ties
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m1_grant   <= 1'b0;
			m2_grant   <= 1'b0;
			bus_busy   <= 1'b0;
			sel_master <= 1'b0;
			sel_slave  <= '0;
		end else if (!bus_busy) begin
			if (m1_request) begin
				m1_grant   <= 1'b1;
				bus_busy   <= 1'b1;
				sel_master <= 1'b0;     // route master 1
				sel_slave  <= m1_slave;
			end else if (m2_request) begin
				m2_grant   <= 1'b1;
				bus_busy   <= 1'b1;
				sel_master <= 1'b1;
				sel_slave  <= m2_slave;
			end
		end else if (trans_done) begin
			// bus free from the next cycle
			m1_grant <= 1'b0;
			m2_grant <= 1'b0;
			bus_busy <= 1'b0;
		end
	end

	a_one_grant: assert property (
		@(posedge clk) disable iff (!rst_n) !(m1_grant && m2_grant)
	) else $error("both masters granted");

endmodule

//--- interconnect/bus_mux.sv
module bus_mux (
	input  logic                bus_busy,
	input  logic                sel_master,
	input  bus_pkg::slave_sel_t sel_slave,
	serial_if.slave             m1_link,
	serial_if.slave             m2_link,
	serial_if.master            s0_link,
	serial_if.master            s1_link,
	serial_if.master            s2_link
);

	logic fwd_valid, fwd_addr, fwd_data, fwd_wr, fwd_rd, fwd_ready;
	logic ret_ready, ret_valid, ret_bit;
	logic m1_sel, m2_sel;
	logic s0_sel, s1_sel, s2_sel;

	assign m1_sel = bus_busy && !sel_master;
	assign m2_sel = bus_busy && sel_master;
	assign s0_sel = bus_busy && sel_slave == bus_pkg::slave_sel_t'(0);
	assign s1_sel = bus_busy && sel_slave == bus_pkg::slave_sel_t'(1);
	assign s2_sel = bus_busy && sel_slave == bus_pkg::slave_sel_t'(2);

	// granted master side
	always_comb begin
		fwd_valid = sel_master ? m2_link.master_valid : m1_link.master_valid;
		fwd_addr  = sel_master ? m2_link.addr_bit     : m1_link.addr_bit;
		fwd_data  = sel_master ? m2_link.data_bit     : m1_link.data_bit;
		fwd_wr    = sel_master ? m2_link.write_en     : m1_link.write_en;
		fwd_rd    = sel_master ? m2_link.read_en      : m1_link.read_en;
		fwd_ready = sel_master ? m2_link.master_ready : m1_link.master_ready;
	end

	// selected slave return path
	always_comb begin
		case (sel_slave)
			bus_pkg::slave_sel_t'(0): {ret_ready, ret_valid, ret_bit} =
				{s0_link.slave_ready, s0_link.slave_valid, s0_link.rdata_bit};
			bus_pkg::slave_sel_t'(1): {ret_ready, ret_valid, ret_bit} =
				{s1_link.slave_ready, s1_link.slave_valid, s1_link.rdata_bit};
			bus_pkg::slave_sel_t'(2): {ret_ready, ret_valid, ret_bit} =
				{s2_link.slave_ready, s2_link.slave_valid, s2_link.rdata_bit};
			default: {ret_ready, ret_valid, ret_bit} = 3'b000; // no such slave
		endcase
	end

	// unselected slaves see an idle master
	assign s0_link.master_valid = s0_sel && fwd_valid;
	assign s0_link.addr_bit     = s0_sel && fwd_addr;
	assign s0_link.data_bit     = s0_sel && fwd_data;
	assign s0_link.write_en     = s0_sel && fwd_wr;
	assign s0_link.read_en      = s0_sel && fwd_rd;
	assign s0_link.master_ready = s0_sel && fwd_ready;

	assign s1_link.master_valid = s1_sel && fwd_valid;
	assign s1_link.addr_bit     = s1_sel && fwd_addr;
	assign s1_link.data_bit     = s1_sel && fwd_data;
	assign s1_link.write_en     = s1_sel && fwd_wr;
	assign s1_link.read_en      = s1_sel && fwd_rd;
	assign s1_link.master_ready = s1_sel && fwd_ready;

	assign s2_link.master_valid = s2_sel && fwd_valid;
	assign s2_link.addr_bit     = s2_sel && fwd_addr;
	assign s2_link.data_bit     = s2_sel && fwd_data;
	assign s2_link.write_en     = s2_sel && fwd_wr;
	assign s2_link.read_en      = s2_sel && fwd_rd;
	assign s2_link.master_ready = s2_sel && fwd_ready;

	// waiting master sees a busy slave
	assign m1_link.slave_ready = m1_sel && ret_ready;
	assign m1_link.slave_valid = m1_sel && ret_valid;
	assign m1_link.rdata_bit   = m1_sel && ret_bit;

	assign m2_link.slave_ready = m2_sel && ret_ready;
	assign m2_link.slave_valid = m2_sel && ret_valid;
	assign m2_link.rdata_bit   = m2_sel && ret_bit;

endmodule

//--- slave/bus_slave.sv
module bus_slave #(
	parameter int mem_addr_len = bus_pkg::slave0_addr_len
) (
	input  logic     clk,
	input  logic     rst_n,
	serial_if.slave  link
);

	bus_pkg::slave_state_t state;
	logic [bus_pkg::bit_cnt_len-1:0] bit_cnt;

	bus_pkg::addr_t addr_sh;   // incoming address
	bus_pkg::data_t data_sh;   // incoming write data
	bus_pkg::data_t tx_sh;     // outgoing read data
	bus_pkg::data_t mem [2**mem_addr_len];

	bus_pkg::addr_t addr_next;
	bus_pkg::data_t data_next;
	logic           addr_take;
	logic           data_take;
	logic           addr_end;
	logic           data_end;

	// shift register value including this cycle's bit
	assign addr_next = {link.addr_bit, addr_sh[bus_pkg::addr_len-1:1]};
	assign data_next = {link.data_bit, data_sh[bus_pkg::data_len-1:1]};

	assign addr_take = link.master_valid &&
		(state == bus_pkg::s_idle || state == bus_pkg::s_get_addr);
	assign data_take = link.master_valid && state == bus_pkg::s_get_data;
	assign addr_end  = link.master_valid && state == bus_pkg::s_get_addr &&
		bit_cnt == bus_pkg::addr_last;
	assign data_end  = data_take && bit_cnt == bus_pkg::data_last;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= bus_pkg::s_idle;
			bit_cnt <= '0;
		end else begin
			case (state)
				bus_pkg::s_idle: begin
					if (link.master_valid) begin // first address bit
						bit_cnt <= 1'b1;
						state   <= bus_pkg::s_get_addr;
					end
				end
				bus_pkg::s_get_addr: begin
					if (addr_end) begin
						bit_cnt <= '0;
						if (link.write_en)
							state <= bus_pkg::s_get_data;
						else if (link.read_en)
							state <= bus_pkg::s_send_data;
						else
							state <= bus_pkg::s_idle;
					end else if (link.master_valid) begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				bus_pkg::s_get_data: begin
					if (data_end) begin
						bit_cnt <= '0;
						state   <= bus_pkg::s_idle;
					end else if (data_take) begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				bus_pkg::s_send_data: begin
					if (link.master_ready) begin
						if (bit_cnt == bus_pkg::data_last) begin
							bit_cnt <= '0;
							state   <= bus_pkg::s_idle;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				default: state <= bus_pkg::s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (addr_take)
			addr_sh <= addr_next;
		if (data_take)
			data_sh <= data_next;
		// a 2k slave drops the top address bit
		if (data_end)
			mem[addr_sh[mem_addr_len-1:0]] <= data_next;
		if (addr_end)
			tx_sh <= mem[addr_next[mem_addr_len-1:0]]; // first bit goes out next cycle
		else if (state == bus_pkg::s_send_data && link.master_ready)
			tx_sh <= tx_sh >> 1;
	end

	assign link.slave_ready = state == bus_pkg::s_idle;
	assign link.slave_valid = state == bus_pkg::s_send_data;
	assign link.rdata_bit   = tx_sh[0];

	// both enables come from the granted master through the mux
	a_one_direction: assert property (
		@(posedge clk) disable iff (!rst_n) !(link.write_en && link.read_en)
	) else $error("write_en and read_en both high");

endmodule

//--- src/bus_system.sv
module bus_system (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                m1_start,
	input  logic                m1_write,
	input  bus_pkg::slave_sel_t m1_slave,
	input  bus_pkg::addr_t      m1_addr,
	input  bus_pkg::data_t      m1_wdata,
	output logic                m1_busy,
	output logic                m1_done,
	output bus_pkg::data_t      m1_rdata,
	input  logic                m2_start,
	input  logic                m2_write,
	input  bus_pkg::slave_sel_t m2_slave,
	input  bus_pkg::addr_t      m2_addr,
	input  bus_pkg::data_t      m2_wdata,
	output logic                m2_busy,
	output logic                m2_done,
	output bus_pkg::data_t      m2_rdata
);

	logic m1_request, m2_request;
	logic m1_grant, m2_grant;
	logic bus_busy, sel_master;
	logic trans_done;
	bus_pkg::slave_sel_t m1_req_slave, m2_req_slave, sel_slave;

	serial_if m1_link ();
	serial_if m2_link ();
	serial_if s0_link ();
	serial_if s1_link ();
	serial_if s2_link ();

	assign trans_done = m1_done | m2_done; // only the granted master can finish

	bus_master master1 (
		.clk(clk), .rst_n(rst_n),
		.start(m1_start), .write(m1_write), .slave(m1_slave), .addr(m1_addr), .wdata(m1_wdata),
		.busy(m1_busy), .done(m1_done), .rdata(m1_rdata),
		.request(m1_request), .req_slave(m1_req_slave), .grant(m1_grant),
		.link(m1_link.master)
	);

	bus_master master2 (
		.clk(clk), .rst_n(rst_n),
		.start(m2_start), .write(m2_write), .slave(m2_slave), .addr(m2_addr), .wdata(m2_wdata),
		.busy(m2_busy), .done(m2_done), .rdata(m2_rdata),
		.request(m2_request), .req_slave(m2_req_slave), .grant(m2_grant),
		.link(m2_link.master)
	);

	bus_arbiter arbiter (
		.clk(clk), .rst_n(rst_n),
		.m1_request(m1_request), .m2_request(m2_request),
		.m1_slave(m1_req_slave), .m2_slave(m2_req_slave),
		.trans_done(trans_done),
		.m1_grant(m1_grant), .m2_grant(m2_grant),
		.bus_busy(bus_busy), .sel_master(sel_master), .sel_slave(sel_slave)
	);

	bus_mux mux (
		.bus_busy(bus_busy), .sel_master(sel_master), .sel_slave(sel_slave),
		.m1_link(m1_link.slave), .m2_link(m2_link.slave),
		.s0_link(s0_link.master), .s1_link(s1_link.master), .s2_link(s2_link.master)
	);

	bus_slave #(.mem_addr_len(bus_pkg::slave0_addr_len)) slave_4k (
		.clk(clk), .rst_n(rst_n), .link(s0_link.slave)
	);

	bus_slave #(.mem_addr_len(bus_pkg::slave1_addr_len)) slave_2k1 (
		.clk(clk), .rst_n(rst_n), .link(s1_link.slave)
	);

	bus_slave #(.mem_addr_len(bus_pkg::slave1_addr_len)) slave_2k2 (
		.clk(clk), .rst_n(rst_n), .link(s2_link.slave)
	);

endmodule

//--- bench/tb_bus_system.sv
module tb_bus_system;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int max_trans = 300;       // upper bound on commands in all tests
	localparam int cycles_per_trans = 40; // one transaction plus arbitration slack
	localparam int cycle_limit = max_trans * cycles_per_trans;

	logic clk = 1'b0;
	logic rst_n;
	logic m1_start, m1_write, m1_busy, m1_done;
	logic m2_start, m2_write, m2_busy, m2_done;
	bus_pkg::slave_sel_t m1_slave, m2_slave;
	bus_pkg::addr_t m1_addr, m2_addr;
	bus_pkg::data_t m1_wdata, m2_wdata, m1_rdata, m2_rdata;

	integer seed;
	int cycles = 0;
	int done_cnt [2];
	int issued [2];

	// memory model, one per slave, keyed by the truncated address
	bus_pkg::data_t mem0 [int];
	bus_pkg::data_t mem1 [int];
	bus_pkg::data_t mem2 [int];
	bus_pkg::slave_sel_t wr_slave_q [$]; // locations already written
	bus_pkg::addr_t wr_addr_q [$];

	bus_system dut (
		.clk(clk), .rst_n(rst_n),
		.m1_start(m1_start), .m1_write(m1_write), .m1_slave(m1_slave), .m1_addr(m1_addr),
		.m1_wdata(m1_wdata), .m1_busy(m1_busy), .m1_done(m1_done), .m1_rdata(m1_rdata),
		.m2_start(m2_start), .m2_write(m2_write), .m2_slave(m2_slave), .m2_addr(m2_addr),
		.m2_wdata(m2_wdata), .m2_busy(m2_busy), .m2_done(m2_done), .m2_rdata(m2_rdata)
	);

	always #10 clk = ~clk;

	always @(negedge clk) begin
		if (rst_n) begin
			if (m1_done)
				done_cnt[0]++;
			if (m2_done)
				done_cnt[1]++;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			fail_run($sformatf("simulation hung: tests still running after %0d cycles",
				cycle_limit));
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_data(input bus_pkg::data_t got, input bus_pkg::data_t exp,
		input string what);
		if (got !== exp)
			fail_run($sformatf("Error at %0t ns: %s gave %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic rand_below(input int n, output int r);
		r = $unsigned($random(seed)) % n;
	endtask

	task automatic rand_fields(output bus_pkg::slave_sel_t s, output bus_pkg::addr_t a,
		output bus_pkg::data_t d);
		int k;
		rand_below(bus_pkg::slave_count, k);
		s = bus_pkg::slave_sel_t'(k);
		a = bus_pkg::addr_t'($random(seed));
		d = bus_pkg::data_t'($random(seed));
	endtask

	// slave 0 is 4k, the others 2k and alias on bit 11
	function automatic int model_key(bus_pkg::slave_sel_t s, bus_pkg::addr_t a);
		int len;
		len = (s == 0) ? bus_pkg::slave0_addr_len : bus_pkg::slave1_addr_len;
		return int'(a) % (1 << len);
	endfunction

	function automatic bus_pkg::data_t model_read(bus_pkg::slave_sel_t s, bus_pkg::addr_t a);
		int k;
		k = model_key(s, a);
		case (s)
			0: return mem0[k];
			1: return mem1[k];
			default: return mem2[k];
		endcase
	endfunction

	task automatic model_write(input bus_pkg::slave_sel_t s, input bus_pkg::addr_t a,
		input bus_pkg::data_t d);
		int k;
		k = model_key(s, a);
		case (s)
			0: mem0[k] = d;
			1: mem1[k] = d;
			default: mem2[k] = d;
		endcase
		wr_slave_q.push_back(s);
		wr_addr_q.push_back(a);
	endtask

	function automatic logic busy_of(int m);
		return (m == 0) ? m1_busy : m2_busy;
	endfunction

	function automatic logic done_of(int m);
		return (m == 0) ? m1_done : m2_done;
	endfunction

	function automatic bus_pkg::data_t rdata_of(int m);
		return (m == 0) ? m1_rdata : m2_rdata;
	endfunction

	// one cycle start strobe with the command fields
	task automatic drive_start(input int m, input logic wr, input bus_pkg::slave_sel_t s,
		input bus_pkg::addr_t a, input bus_pkg::data_t d);
		@(posedge clk);
		if (m == 0) begin
			m1_start <= 1'b1;
			m1_write <= wr;
			m1_slave <= s;
			m1_addr  <= a;
			m1_wdata <= d;
		end else begin
			m2_start <= 1'b1;
			m2_write <= wr;
			m2_slave <= s;
			m2_addr  <= a;
			m2_wdata <= d;
		end
		@(posedge clk);
		if (m == 0)
			m1_start <= 1'b0;
		else
			m2_start <= 1'b0;
	endtask

	task automatic run_cmd(input int m, input logic wr, input bus_pkg::slave_sel_t s,
		input bus_pkg::addr_t a, input bus_pkg::data_t d, output bus_pkg::data_t got);
		bus_pkg::data_t exp;
		while (busy_of(m))
			@(negedge clk);
		drive_start(m, wr, s, a, d);
		issued[m]++;
		do begin
			@(negedge clk);
			if (!done_of(m))
				check_flag(busy_of(m), 1'b1,
					$sformatf("master %0d busy during command", m + 1));
		end while (!done_of(m));
		check_flag(busy_of(m), 1'b0, $sformatf("master %0d busy at done", m + 1));
		got = rdata_of(m);
		if (wr) begin
			model_write(s, a, d); // model follows done order
		end else begin
			exp = model_read(s, a);
			check_data(got, exp, $sformatf("master %0d read of slave %0d at %h", m + 1, s, a));
		end
	endtask

	task automatic check_done_counts();
		@(posedge clk); // let the done monitor catch up
		check_flag(done_cnt[0] == issued[0], 1'b1, "one done per command on master 1");
		check_flag(done_cnt[1] == issued[1], 1'b1, "one done per command on master 2");
	endtask

	task automatic writes_then_reads(input int n);
		bus_pkg::slave_sel_t s_list [$];
		bus_pkg::addr_t a_list [$];
		bus_pkg::slave_sel_t s;
		bus_pkg::addr_t a;
		bus_pkg::data_t d, got;
		for (int i = 0; i < n; i++) begin
			rand_fields(s, a, d);
			run_cmd(0, 1'b1, s, a, d, got);
			s_list.push_back(s);
			a_list.push_back(a);
		end
		for (int i = 0; i < n; i++)
			run_cmd(0, 1'b0, s_list[i], a_list[i], '0, got);
	endtask

	task automatic alias_reads(input int n);
		bus_pkg::slave_sel_t s;
		bus_pkg::addr_t a;
		bus_pkg::data_t d, got;
		for (int i = 0; i < n; i++) begin
			rand_fields(s, a, d);
			s = bus_pkg::slave_sel_t'(1 + i % 2); // 2k slaves only
			run_cmd(1, 1'b1, s, a | 12'h800, d, got);
			run_cmd(1, 1'b0, s, a & 12'h7ff, '0, got);
			check_data(got, d, "aliased read of a 2k slave");
		end
	endtask

	// both masters strobe in the same cycle at the same location
	task automatic simultaneous_starts(input int rounds);
		bus_pkg::slave_sel_t s;
		bus_pkg::addr_t a;
		bus_pkg::data_t d1, d2, g1, g2;
		for (int r = 0; r < rounds; r++) begin
			rand_fields(s, a, d1);
			d2 = ~d1;
			fork
				run_cmd(0, 1'b1, s, a, d1, g1);
				run_cmd(1, 1'b1, s, a, d2, g2);
			join
			fork
				run_cmd(0, 1'b0, s, a, '0, g1);
				run_cmd(1, 1'b0, s, a, '0, g2);
			join
			check_done_counts();
		end
	endtask

	task automatic start_while_busy();
		bus_pkg::slave_sel_t s;
		bus_pkg::addr_t a;
		bus_pkg::data_t d, got;
		rand_fields(s, a, d);
		fork
			run_cmd(0, 1'b1, s, a, d, got);
			begin
				repeat (6) @(posedge clk); // mid transfer
				drive_start(0, 1'b1, s, a, ~d);
			end
		join
		repeat (cycles_per_trans) @(posedge clk);
		check_done_counts();
		run_cmd(0, 1'b0, s, a, '0, got);
		check_data(got, d, "memory after ignored start");
	endtask

	task automatic random_cmd(input int m);
		int pick;
		int idx;
		bus_pkg::slave_sel_t s;
		bus_pkg::addr_t a;
		bus_pkg::data_t d, got;
		rand_below(2, pick);
		if (pick == 0 || wr_addr_q.size() == 0) begin
			rand_fields(s, a, d);
			run_cmd(m, 1'b1, s, a, d, got);
		end else begin
			rand_below(wr_addr_q.size(), idx); // only written locations are read
			run_cmd(m, 1'b0, wr_slave_q[idx], wr_addr_q[idx], '0, got);
		end
	endtask

	initial begin
		seed = 45;
		rst_n = 1'b0;
		m1_start = 1'b0;
		m1_write = 1'b0;
		m1_slave = '0;
		m1_addr = '0;
		m1_wdata = '0;
		m2_start = 1'b0;
		m2_write = 1'b0;
		m2_slave = '0;
		m2_addr = '0;
		m2_wdata = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		check_flag(m1_busy, 1'b0, "master 1 busy after reset");
		check_flag(m1_done, 1'b0, "master 1 done after reset");
		check_flag(m2_busy, 1'b0, "master 2 busy after reset");
		check_flag(m2_done, 1'b0, "master 2 done after reset");

		writes_then_reads(20);
		alias_reads(4);
		simultaneous_starts(8);
		start_while_busy();
		fork
			repeat (100) random_cmd(0);
			repeat (100) random_cmd(1);
		join
		check_done_counts();

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- sim.f
common/bus_pkg.sv
common/serial_if.sv
master/bus_master.sv
interconnect/bus_arbiter.sv
interconnect/bus_mux.sv
slave/bus_slave.sv
src/bus_system.sv
bench/tb_bus_system.sv
